// ==== Bender.yml ====
package:
  name: pool_engine

sources:
  # RTL, package first
  - files:
      - verilog/pool_pkg.sv
      - verilog/atom_deserializer.sv
      - verilog/window_max.sv
      - verilog/line_control.sv
      - verilog/result_serializer.sv
      - verilog/pool_engine.sv

  # Testbench
  - target: simulation
    files:
      - bench/pool_engine_tb.sv

// ==== bench/pool_engine_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module pool_engine_tb;

	localparam int IDLE_WORDS  = 16 + 7;                      // Full atom plus an odd tail
	localparam int TOTAL_WORDS = 16 + 64 + 96 + IDLE_WORDS + 16; // Every strobe the tests send
	localparam int MAX_GAP     = 1;                      // Idle cycles after a word, at most
	localparam int WB_CYCLES   = pool_pkg::LANES + 1;    // Busy falling to last strobe sampled

	logic                clk;
	logic                rst;
	logic                i_start;
	pool_pkg::pool_cfg_t i_cfg;
	pool_pkg::lane_t     i_data;
	logic                i_data_we;
	logic                o_wr_en;
	pool_pkg::lane_t     o_wr_data;
	logic                o_busy;
	logic                o_line_done;

	integer              seed;
	string               test_name;
	pool_pkg::lane_t     win_q[$];   // Words of the window being sent
	pool_pkg::lane_t     exp_q[$];   // Expected write-back, lane 0 first
	pool_pkg::lane_t     exp_word;
	int                  wr_count;   // Write strobes seen so far
	int                  done_count; // Line done pulses seen so far
	int                  wr_before;
	int                  done_before;

	pool_engine pool_engine_i (
		.clk         (clk),
		.rst         (rst),
		.i_start     (i_start),
		.i_cfg       (i_cfg),
		.i_data      (i_data),
		.i_data_we   (i_data_we),
		.o_wr_en     (o_wr_en),
		.o_wr_data   (o_wr_data),
		.o_busy      (o_busy),
		.o_line_done (o_line_done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk; // 20 ns period
	end

	task automatic abort_run(input string reason);
		$display("ERROR: %s (test %s, time %0t)", reason, test_name, $time);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic report_mismatch(input string what, input logic signed [31:0] expected,
			input logic signed [31:0] actual);
		$display("CHECK FAILED %s: %s expected %0d actual %0d",
			test_name, what, expected, actual);
		abort_run("value mismatch");
	endtask

	// Per-lane signed maximum over all atoms of one window
	function automatic pool_pkg::atom_t lane_maxima(input pool_pkg::lane_t words[$]);
		pool_pkg::atom_t mx;
		int              n_atoms;
		n_atoms = words.size() / pool_pkg::LANES;
		for (int l = 0; l < pool_pkg::LANES; l++)
			mx[l] = words[l]; // First atom opens the window
		for (int a = 1; a < n_atoms; a++) begin
			for (int l = 0; l < pool_pkg::LANES; l++) begin
				if (words[a * pool_pkg::LANES + l] > mx[l])
					mx[l] = words[a * pool_pkg::LANES + l];
			end
		end
		return mx;
	endfunction

	// Called on a falling edge, returns on one
	task automatic send_word(input pool_pkg::lane_t w);
		int gap;
		i_data    = w;
		i_data_we = 1'b1;
		@(negedge clk);
		i_data_we = 1'b0;
		gap = $unsigned($random(seed)) % (MAX_GAP + 1); // Random idle gap
		repeat (gap) @(negedge clk);
	endtask

	task automatic send_window(input int n_atoms, input bit neg_low_lanes);
		pool_pkg::atom_t mx;
		pool_pkg::lane_t w;
		win_q.delete();
		for (int i = 0; i < n_atoms * pool_pkg::LANES; i++) begin
			w = pool_pkg::lane_t'($random(seed));
			if (neg_low_lanes && ((i % pool_pkg::LANES) < 4))
				w[pool_pkg::DATA_W-1] = 1'b1; // Lanes 0 to 3 all negative
			win_q.push_back(w);
			send_word(w);
		end
		mx = lane_maxima(win_q);
		for (int l = 0; l < pool_pkg::LANES; l++)
			exp_q.push_back(mx[l]); // Lane 0 leaves first
	endtask

	task automatic run_line(input string name, input int window, input int o_side,
			input bit neg_low_lanes);
		test_name    = name;
		i_cfg.window = pool_pkg::count_t'(window);
		i_cfg.o_side = pool_pkg::count_t'(o_side);
		i_start      = 1'b1;
		@(negedge clk);
		i_start = 1'b0;
		for (int k = 0; k < o_side; k++)
			send_window(window, neg_low_lanes);
		while (o_busy)
			@(negedge clk); // Busy drops with the final result strobe
		repeat (WB_CYCLES) @(negedge clk); // Last window still writing back
	endtask

	// Compare write-back against the expected queue
	always @(posedge clk) begin
		if (!rst && o_line_done)
			done_count++;
		if (!rst && o_wr_en) begin
			wr_count++;
			assert (exp_q.size() != 0) begin
				exp_word = exp_q.pop_front();
				assert (o_wr_data === exp_word)
				else report_mismatch("write data", exp_word, o_wr_data);
			end else begin
				abort_run("write strobe with no expected word");
			end
		end
	end

	initial begin
		#(TOTAL_WORDS * 60 + 2000);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		seed       = 32'h46e9;
		rst        = 1'b1;
		i_start    = 1'b0;
		i_cfg      = '0;
		i_data     = '0;
		i_data_we  = 1'b0;
		wr_count   = 0;
		done_count = 0;
		test_name  = "reset_state";
		repeat (2) @(negedge clk); // Two rising edges in reset
		rst = 1'b0;

		// Outputs quiet until the first start
		repeat (4) begin
			@(posedge clk);
			assert (!o_wr_en && !o_busy && !o_line_done)
			else abort_run("an output is active after reset");
		end
		@(negedge clk);

		run_line("single_atom", 1, 1, 1'b0);    // Output equals input
		run_line("window_of_four", 4, 1, 1'b1); // Signed max incl. negatives

		wr_before   = wr_count;
		done_before = done_count;
		run_line("three_windows", 2, 3, 1'b0);
		assert ((wr_count - wr_before) == 48)
		else report_mismatch("write strobes", 48, wr_count - wr_before);
		assert ((done_count - done_before) == 1)
		else report_mismatch("line done pulses", 1, done_count - done_before);
		assert (!o_busy) else abort_run("busy still high after the line");

		// Idle words, more than an atom and not a multiple of it
		test_name = "idle_words";
		wr_before = wr_count;
		repeat (IDLE_WORDS) send_word(pool_pkg::lane_t'($random(seed)));
		repeat (4) @(negedge clk); // Past the write latency of the last word
		assert (wr_count == wr_before)
		else report_mismatch("write strobes while idle", 0, wr_count - wr_before);
		run_line("realign_after_idle", 1, 1, 1'b0);

		assert (exp_q.size() == 0) else abort_run("expected words left over");
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pool_engine.f ====
verilog/pool_pkg.sv
verilog/atom_deserializer.sv
verilog/window_max.sv
verilog/line_control.sv
verilog/result_serializer.sv
verilog/pool_engine.sv
bench/pool_engine_tb.sv

// ==== verilog/atom_deserializer.sv ====
`timescale 1ns/10ps
`default_nettype none

module atom_deserializer (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      i_busy,       // Line in progress
	input  wire  pool_pkg::lane_t    i_data,       // Serial word from DMA read port
	input  wire                      i_data_we,    // One strobe per word
	output pool_pkg::atom_t          o_atom,       // Collected atom
	output logic                     o_atom_valid  // One-cycle pulse per atom
);

	pool_pkg::lane_idx_t word_cnt; // Words taken in the current atom
	logic                accept;

	// Words outside a line are dropped
	assign accept = i_data_we & i_busy;

	// Control path
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			word_cnt     <= '0;
			o_atom_valid <= 1'b0;
		end else begin
			o_atom_valid <= 1'b0;
			if (!i_busy) begin
				word_cnt <= '0; // Realign lanes for the next line
			end else if (accept) begin
				word_cnt <= word_cnt + pool_pkg::lane_idx_t'(1); // Wraps after lane 15
				if (word_cnt == pool_pkg::lane_idx_t'(pool_pkg::LANES - 1))
					o_atom_valid <= 1'b1; // Sixteenth word seen
			end
		end
	end

	// Shift in from the top, first word lands in lane 0
	always_ff @(posedge clk) begin
		if (accept)
			o_atom <= {i_data, o_atom[pool_pkg::LANES-1:1]};
	end

endmodule

`default_nettype wire

// ==== verilog/line_control.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_control (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      i_start,       // Line start pulse
	input  wire  pool_pkg::count_t   i_o_side,      // Windows per line
	input  wire                      i_window_done, // Result strobe from window_max
	output logic                     o_busy,        // High during a line
	output logic                     o_line_done    // Pulse on the last window
);

	pool_pkg::line_state_t state;
	pool_pkg::count_t      win_cnt; // Windows finished in this line
	logic                  last_win;

	assign o_busy = (state == pool_pkg::LINE_BUSY);

	// Final window of the line
	assign last_win = ((win_cnt + pool_pkg::count_t'(1)) == i_o_side);

	// Same cycle as the final result strobe, busy drops at the following edge
	assign o_line_done = o_busy & i_window_done & last_win;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state   <= pool_pkg::LINE_IDLE;
			win_cnt <= '0;
		end else begin
			case (state)
				pool_pkg::LINE_IDLE: begin
					win_cnt <= '0;
					if (i_start)
						state <= pool_pkg::LINE_BUSY;
				end
				pool_pkg::LINE_BUSY: begin
					if (i_window_done) begin
						if (last_win) begin
							state   <= pool_pkg::LINE_IDLE; // Line complete
							win_cnt <= '0;
						end else begin
							win_cnt <= win_cnt + pool_pkg::count_t'(1);
						end
					end
				end
				default: begin
					state <= pool_pkg::LINE_IDLE;
				end
			endcase
		end
	end

	// Start is only legal between lines
	a_start_idle: assert property (
		@(posedge clk) disable iff (rst)
		i_start |-> !o_busy
	) else $error("start pulse while a line is running");

endmodule

`default_nettype wire

// ==== verilog/pool_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module pool_engine (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       i_start,     // Line start pulse
	input  wire  pool_pkg::pool_cfg_t i_cfg,       // Stable during the line
	input  wire  pool_pkg::lane_t     i_data,      // DMA read word
	input  wire                       i_data_we,   // DMA read strobe
	output logic                      o_wr_en,     // DMA write strobe
	output pool_pkg::lane_t           o_wr_data,   // DMA write word
	output logic                      o_busy,
	output logic                      o_line_done
);

	pool_pkg::count_t cfg_window; // Atoms per window
	pool_pkg::count_t cfg_o_side; // Windows per line
	pool_pkg::atom_t  atom;
	logic             atom_valid;
	pool_pkg::atom_t  result;
	logic             result_valid;

	assign cfg_window = i_cfg.window;
	assign cfg_o_side = i_cfg.o_side;

	line_control line_control_i (
		.clk           (clk),
		.rst           (rst),
		.i_start       (i_start),
		.i_o_side      (cfg_o_side),
		.i_window_done (result_valid),
		.o_busy        (o_busy),
		.o_line_done   (o_line_done)
	);

	atom_deserializer atom_deserializer_i (
		.clk          (clk),
		.rst          (rst),
		.i_busy       (o_busy),
		.i_data       (i_data),
		.i_data_we    (i_data_we),
		.o_atom       (atom),
		.o_atom_valid (atom_valid)
	);

	window_max window_max_i (
		.clk            (clk),
		.rst            (rst),
		.i_busy         (o_busy),
		.i_window       (cfg_window),
		.i_atom         (atom),
		.i_atom_valid   (atom_valid),
		.o_result       (result),
		.o_result_valid (result_valid)
	);

	// Write-back of the last window outlives busy
	result_serializer result_serializer_i (
		.clk            (clk),
		.rst            (rst),
		.i_result       (result),
		.i_result_valid (result_valid),
		.o_wr_en        (o_wr_en),
		.o_wr_data      (o_wr_data)
	);

endmodule

`default_nettype wire

// ==== verilog/pool_pkg.sv ====
`default_nettype none

package pool_pkg;

	localparam int LANES   = 16; // Channels per atom
	localparam int DATA_W  = 16; // One DMA word
	localparam int COUNT_W = 8;  // Window and line counters

	// Signed data word, one per lane
	typedef logic signed [DATA_W-1:0] lane_t;

	typedef logic [$clog2(LANES)-1:0] lane_idx_t; // Lane position inside an atom
	typedef logic [COUNT_W-1:0]       count_t;    // Atom or window count

	// 1x1x16 slice of channels, lane 0 in the low word
	typedef lane_t [LANES-1:0] atom_t;

	// Static line configuration
	typedef struct packed {
		count_t window; // Atoms per window, also the stride
		count_t o_side; // Windows per line
	} pool_cfg_t;

	typedef enum logic {
		LINE_IDLE,
		LINE_BUSY
	} line_state_t;

endpackage

`default_nettype wire

// ==== verilog/result_serializer.sv ====
`timescale 1ns/10ps
`default_nettype none

module result_serializer (
	input  wire                      clk,
	input  wire                      rst,
	input  wire  pool_pkg::atom_t    i_result,       // Window maxima
	input  wire                      i_result_valid, // Load strobe
	output logic                     o_wr_en,        // DMA write strobe
	output pool_pkg::lane_t          o_wr_data       // One lane per strobe
);

	pool_pkg::atom_t     res_buf;  // Latched maxima
	pool_pkg::lane_idx_t lane_idx; // Next lane to send
	logic                active;   // Write-back running
	logic                last_lane;

	assign last_lane = (lane_idx == pool_pkg::lane_idx_t'(pool_pkg::LANES - 1));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active   <= 1'b0;
			lane_idx <= '0;
			o_wr_en  <= 1'b0;
		end else begin
			o_wr_en <= active;
			if (active) begin
				lane_idx <= lane_idx + pool_pkg::lane_idx_t'(1);
				if (last_lane)
					active <= 1'b0;
			end
			// A new result may land on the edge that sends lane 15
			if (i_result_valid) begin
				active   <= 1'b1;
				lane_idx <= '0;
			end
		end
	end

	// Payload
	always_ff @(posedge clk) begin
		if (i_result_valid)
			res_buf <= i_result;
		o_wr_data <= res_buf[lane_idx]; // Old buffer still read on a reload edge
	end

	// No back-pressure, so a window result must not cut a write-back short
	a_no_overrun: assert property (
		@(posedge clk) disable iff (rst)
		i_result_valid |-> (!active || last_lane)
	) else $error("result arrived during write-back");

endmodule

`default_nettype wire

// ==== verilog/window_max.sv ====
`timescale 1ns/10ps
`default_nettype none

module window_max (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      i_busy,        // Line in progress
	input  wire  pool_pkg::count_t   i_window,      // Atoms per window
	input  wire  pool_pkg::atom_t    i_atom,        // Atom from deserializer
	input  wire                      i_atom_valid,  // One pulse per atom
	output pool_pkg::atom_t          o_result,      // Per-lane maxima
	output logic                     o_result_valid // Window complete
);

	pool_pkg::count_t atom_cnt;  // Atoms already folded into the window
	pool_pkg::count_t atom_next;
	pool_pkg::atom_t  max_next;  // Maxima including the incoming atom
	logic             take;
	logic             first;     // Incoming atom opens a window
	logic             last;      // Incoming atom closes a window

	assign take      = i_atom_valid & i_busy;
	assign atom_next = atom_cnt + pool_pkg::count_t'(1);
	assign first     = (atom_cnt == '0);
	assign last      = (atom_next == i_window);

	// Per-lane signed compare
	always_comb begin
		for (int l = 0; l < pool_pkg::LANES; l++) begin
			if (first || (i_atom[l] > o_result[l]))
				max_next[l] = i_atom[l]; // New maximum or window start
			else
				max_next[l] = o_result[l];
		end
	end

	// Window count and result strobe
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			atom_cnt       <= '0;
			o_result_valid <= 1'b0;
		end else begin
			o_result_valid <= 1'b0;
			if (!i_busy) begin
				atom_cnt <= '0;
			end else if (take) begin
				if (last) begin
					atom_cnt       <= '0; // Stride equals window, no overlap
					o_result_valid <= 1'b1;
				end else begin
					atom_cnt <= atom_next;
				end
			end
		end
	end

	// Running maxima, held for the serializer until the next atom
	always_ff @(posedge clk) begin
		if (take)
			o_result <= max_next;
	end

	// A zero window would never close and the line would hang
	a_window_nonzero: assert property (
		@(posedge clk) disable iff (rst)
		i_busy |-> (i_window != '0)
	) else $error("window length is zero during a line");

endmodule

`default_nettype wire
